// File: tb.f
src/uart_pkg.sv
src/uart_bus_if.sv
src/uart_bus_decode.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_channel.sv
src/uart_read_mux.sv
src/uart_multi.sv
test/tb_uart_multi.sv

// File: Bender.yml
package:
  name: uart_multi

sources:
  - src/uart_pkg.sv
  - src/uart_bus_if.sv
  - src/uart_bus_decode.sv
  - src/uart_tx.sv
  - src/uart_rx.sv
  - src/uart_channel.sv
  - src/uart_read_mux.sv
  - src/uart_multi.sv
  - target: test
    files:
      - test/tb_uart_multi.sv

// File: test/tb_uart_multi.sv
// ==================================================
// directed testbench for the multi-channel UART
// bus read and write tasks, serial monitor, serial
// driver, channel 0 and channel 1 in loopback
// ==================================================

`timescale 1ns/1ns

module tb_uart_multi import uart_pkg::*; ();

    localparam int CPB     = 8;                     // clocks per bit
    localparam int TIMEOUT = 3000;                  // ~8 frames of 80 cycles plus polling
    localparam logic [7:0] BUSY  = 8'h01;           // STATUS bit 0
    localparam logic [7:0] VALID = 8'h02;           // STATUS bit 1
    localparam logic [7:0] OVR   = 8'h04;           // STATUS bit 2
    localparam logic [7:0] FERR  = 8'h08;           // STATUS bit 3

    logic            clk, arst_n, en, wr;
    logic [REG_AW:0] addr;                          // channel bit, then offset
    logic [7:0]      wdata, rdata;
    logic [1:0]      rx, tx;
    logic            drv_sel, drv_line;             // serial driver takes over rx[1]
    logic [7:0]      held_byte;                     // last good byte sent to ch1
    int              cycle = 0;
    int              errors = 0;
    int              tests = 0;
    int              err_mark = 0;                  // errors before the running test

    uart_multi #(.NUM_CH(2), .CLKS_PER_BIT(CPB)) uart_multi_i (
        .clk(clk), .arst_n(arst_n), .en(en), .wr(wr), .addr(addr),
        .wdata(wdata), .rdata(rdata), .rx(rx), .tx(tx)
    );

    assign rx[0] = tx[1];                           // crossed loopback
    assign rx[1] = drv_sel ? drv_line : tx[0];

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic compare(input string name, input logic [31:0] got, exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %-10s %s", name, (errors == err_mark) ? "ok" : "failed");
        err_mark = errors;
    endtask

    task automatic bus_write(input int ch, input reg_addr_e off, input logic [7:0] data);
        @(posedge clk);
        en    <= 1'b1;
        wr    <= 1'b1;
        addr  <= {ch[0], off};
        wdata <= data;
        @(posedge clk);                             // write taken here
        en <= 1'b0;
        wr <= 1'b0;
    endtask

    task automatic bus_read(input int ch, input reg_addr_e off, output logic [7:0] data);
        @(posedge clk);
        en   <= 1'b1;
        wr   <= 1'b0;
        addr <= {ch[0], off};
        @(posedge clk);
        en <= 1'b0;
        @(negedge clk);
        data = rdata;                               // one cycle after the strobe
    endtask

    // STATUS reads until the masked flags match
    task automatic poll_status(input int ch, input logic [7:0] mask, want,
                               output logic [7:0] st);
        int n;
        n = 0;
        do begin
            bus_read(ch, REG_STATUS, st);
            n++;
        end while ((st & mask) != want && n < 100);
        if ((st & mask) != want) begin
            $display("channel %0d: STATUS flags not seen after %0d reads", ch, n);
            errors++;
        end
    endtask

    // called on the edge that starts the frame, samples each bit mid-period
    task automatic capture_frame(input int ch, output logic [9:0] frame);
        for (int k = 0; k < 10; k++) begin
            repeat (CPB / 2) @(posedge clk);
            @(negedge clk);
            frame[k] = tx[ch];                      // start, lsb .. msb, stop
            repeat (CPB - CPB / 2) @(posedge clk);
        end
    endtask

    task automatic send_frame(input logic [7:0] b, input logic stop);
        logic [9:0] bits;
        bits = {stop, b, 1'b0};
        for (int k = 0; k < 10; k++) begin
            @(posedge clk);
            drv_line <= bits[k];
            repeat (CPB - 1) @(posedge clk);
        end
        @(posedge clk);
        drv_line <= 1'b1;                           // back to idle
    endtask

    task automatic reset_state();
        logic [7:0] st;
        @(negedge clk);
        compare("tx", tx, 2'b11);
        compare("rdata", rdata, 0);
        for (int c = 0; c < 2; c++) begin
            bus_read(c, REG_STATUS, st);
            compare($sformatf("ch%0d STATUS", c), st, 0);
        end
        end_test("reset");
    endtask

    task automatic tx_frame();
        int t0;
        logic [7:0] b, st;
        logic [9:0] fr;
        b = 8'($urandom);
        bus_write(0, REG_DATA, b);
        t0 = cycle;                                 // edge that took the write
        fork
            capture_frame(0, fr);
            begin
                @(negedge clk);
                compare("tx[0] start", tx[0], 0);   // low from the next cycle
                bus_read(0, REG_STATUS, st);
                compare("ch0 tx_busy", st & BUSY, BUSY);
                while (cycle != t0 + 10 * CPB - 2) @(posedge clk);
                bus_read(0, REG_STATUS, st);        // captured on the last busy edge
                compare("ch0 tx_busy last", st & BUSY, BUSY);
            end
        join
        bus_read(0, REG_STATUS, st);
        compare("ch0 tx_busy end", st & BUSY, 0);
        compare("tx[0] frame", fr, {1'b1, b, 1'b0});
        poll_status(1, VALID, VALID, st);           // drain the loopback copy
        bus_read(1, REG_DATA, st);
        compare("ch1 DATA", st, b);
        end_test("tx frame");
    endtask

    task automatic loopback();
        logic [7:0] b, st;
        for (int src = 0; src < 2; src++) begin
            b = 8'($urandom);
            bus_write(src, REG_DATA, b);
            poll_status(1 - src, VALID, VALID, st);
            bus_read(1 - src, REG_DATA, st);
            compare($sformatf("ch%0d DATA", 1 - src), st, b);
            bus_read(1 - src, REG_STATUS, st);
            compare($sformatf("ch%0d STATUS", 1 - src), st, 0);
        end
        end_test("loopback");
    endtask

    task automatic overrun();
        logic [7:0] b0, b1, st;
        b0 = 8'($urandom);
        b1 = b0 ^ (8'($urandom) | 8'h01);           // always differs from b0
        bus_write(0, REG_DATA, b0);
        poll_status(0, BUSY, 0, st);
        bus_write(0, REG_DATA, b1);                 // ch1 byte still unread
        poll_status(1, OVR, OVR, st);
        compare("ch1 STATUS", st, VALID | OVR);
        bus_read(1, REG_DATA, st);
        compare("ch1 DATA", st, b1);
        bus_read(1, REG_STATUS, st);
        compare("ch1 STATUS cleared", st, 0);
        end_test("overrun");
    endtask

    task automatic busy_drop();
        logic [7:0] st;
        logic [9:0] fr;
        held_byte = 8'($urandom);
        bus_write(0, REG_DATA, held_byte);
        fork
            capture_frame(0, fr);
            bus_write(0, REG_DATA, ~held_byte);     // lands mid-frame
        join
        compare("tx[0] frame", fr, {1'b1, held_byte, 1'b0});
        poll_status(1, VALID, VALID, st);
        bus_read(1, REG_DATA, st);
        compare("ch1 DATA", st, held_byte);
        bus_read(0, REG_STATUS, st);
        compare("ch0 STATUS", st, 0);               // no second frame
        compare("tx[0] idle", tx[0], 1);
        end_test("busy drop");
    endtask

    task automatic framing_error();
        logic [7:0] st;
        @(posedge clk);
        drv_sel <= 1'b1;
        send_frame(~held_byte, 1'b0);               // low stop bit, other payload
        poll_status(1, FERR, FERR, st);
        compare("ch1 STATUS", st, FERR);            // rx_valid stays low
        bus_read(1, REG_DATA, st);
        compare("ch1 DATA", st, held_byte);
        @(posedge clk);
        drv_sel <= 1'b0;
        end_test("frame err");
    endtask

    initial begin
        void'($urandom(32'h8f34_ba4e));
        arst_n   = 1'b0;
        en       = 1'b0;
        wr       = 1'b0;
        addr     = '0;
        wdata    = '0;
        drv_sel  = 1'b0;
        drv_line = 1'b1;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        reset_state();
        tx_frame();
        loopback();
        overrun();
        busy_drop();
        framing_error();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        wait (cycle >= TIMEOUT);
        $display("timeout: run still going after %0d cycles", TIMEOUT);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: src/uart_multi.sv
// ==================================================
// multi-channel UART top level
// decoder, channel array and read data register
// ==================================================

`timescale 1ns/1ns

module uart_multi import uart_pkg::*; #(
    parameter  int NUM_CH       = 2,
    parameter  int CLKS_PER_BIT = 8,
    localparam int SEL_W        = (NUM_CH > 1) ? $clog2(NUM_CH) : 1
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    en,
    input  logic                    wr,
    input  logic [SEL_W+REG_AW-1:0] addr,           // channel index, then offset
    input  logic [7:0]              wdata,
    output logic [7:0]              rdata,
    input  logic [NUM_CH-1:0]       rx,
    output logic [NUM_CH-1:0]       tx
);

    uart_bus_if       ch_bus [NUM_CH] ();           // one bus per channel
    logic [SEL_W-1:0] sel;

    uart_bus_decode #(.NUM_CH(NUM_CH)) decode_i (
        .en(en), .wr(wr), .addr(addr), .wdata(wdata),
        .ch(ch_bus), .sel(sel)
    );

    for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
        uart_channel #(.CLKS_PER_BIT(CLKS_PER_BIT)) channel_i (
            .clk(clk), .arst_n(arst_n), .bus(ch_bus[i]),
            .rx(rx[i]), .tx(tx[i])
        );
    end

    uart_read_mux #(.NUM_CH(NUM_CH)) read_mux_i (
        .clk(clk), .arst_n(arst_n), .ch(ch_bus), .sel(sel),
        .en(en), .wr(wr), .rdata(rdata)
    );

endmodule

// File: src/uart_read_mux.sv
// ==================================================
// host read data register
// captures the selected channel on a read strobe
// ==================================================

`timescale 1ns/1ns

module uart_read_mux #(
    parameter  int NUM_CH = 2,
    localparam int SEL_W  = (NUM_CH > 1) ? $clog2(NUM_CH) : 1
) (
    input  logic             clk,
    input  logic             arst_n,
    uart_bus_if.host_rd      ch [NUM_CH],
    input  logic [SEL_W-1:0] sel,
    input  logic             en,
    input  logic             wr,
    output logic [7:0]       rdata
);

    logic [7:0] ch_rdata [NUM_CH];                  // flattened interface view
    logic [7:0] rd_sel;

    for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
        assign ch_rdata[i] = ch[i].rdata;
    end

    always_comb begin
        rd_sel = '0;                                // unused channel index reads 0
        for (int i = 0; i < NUM_CH; i++) begin
            if (sel == SEL_W'(i)) rd_sel = ch_rdata[i];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) rdata <= '0;
        else if (en && !wr) rdata <= rd_sel;        // held until next read
    end

endmodule

// File: src/uart_channel.sv
// ==================================================
// one UART channel
// DATA and STATUS registers, rx flags, tx and rx
// ==================================================

`timescale 1ns/1ns

module uart_channel import uart_pkg::*; #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic       clk,
    input  logic       arst_n,
    uart_bus_if.channel bus,
    input  logic       rx,
    output logic       tx
);

    reg_addr_e  reg_addr;
    logic       wr_data, rd_data, rd_stat;          // decoded accesses
    logic       tx_busy;
    logic       rx_done, rx_ferr;
    logic [7:0] rx_data;                            // live rx shifter
    logic [7:0] rx_byte;                            // DATA register
    logic       rx_valid, overrun, frame_err;
    logic [7:0] status;

    assign reg_addr = reg_addr_e'(bus.addr);
    assign wr_data  = bus.en &&  bus.wr && (reg_addr == REG_DATA);
    assign rd_data  = bus.en && !bus.wr && (reg_addr == REG_DATA);
    assign rd_stat  = bus.en && !bus.wr && (reg_addr == REG_STATUS);

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) tx_i (
        .clk(clk), .arst_n(arst_n),
        .start(wr_data && !tx_busy),                // write while busy is dropped
        .data(bus.wdata), .tx(tx), .busy(tx_busy)
    );

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) rx_i (
        .clk(clk), .arst_n(arst_n), .rx(rx),
        .data(rx_data), .done(rx_done), .frame_err(rx_ferr)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_valid  <= 1'b0;
            overrun   <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            if (rd_stat) begin                      // read clears error flags
                overrun   <= 1'b0;
                frame_err <= 1'b0;
            end
            if (rx_done && rx_valid && !rd_data) overrun <= 1'b1;   // old byte lost
            if (rx_ferr) frame_err <= 1'b1;                         // set wins over clear
            if (rx_done) rx_valid <= 1'b1;
            else if (rd_data) rx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_done) rx_byte <= rx_data;            // bad frames keep the old byte
    end

    always_comb begin
        status                 = '0;
        status[STAT_TX_BUSY]   = tx_busy;
        status[STAT_RX_VALID]  = rx_valid;
        status[STAT_OVERRUN]   = overrun;
        status[STAT_FRAME_ERR] = frame_err;
        case (reg_addr)
            REG_DATA:   bus.rdata = rx_byte;
            REG_STATUS: bus.rdata = status;
            default:    bus.rdata = '0;             // unmapped offsets
        endcase
    end

endmodule

// File: src/uart_rx.sv
// ==================================================
// UART receiver, 8N1
// input synchronizer, mid-bit sampling, stop check
// ==================================================

`timescale 1ns/1ns

module uart_rx import uart_pkg::*; #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       rx,
    output logic [7:0] data,
    output logic       done,                        // good frame, one cycle
    output logic       frame_err                    // low stop bit, one cycle
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam int HALF  = CLKS_PER_BIT / 2;

    rx_state_e        state;
    logic             rx_meta;                      // first sync stage
    logic             rx_sync;                      // second sync stage
    logic             rx_prev;                      // for edge detect
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift;                        // lsb arrives first
    logic             bit_end;                      // full bit period elapsed

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= RX_IDLE;
            clk_cnt   <= '0;
            bit_idx   <= '0;
            done      <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            done      <= 1'b0;
            frame_err <= 1'b0;
            clk_cnt   <= clk_cnt + CNT_W'(1);
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (rx_prev && !rx_sync) state <= RX_START;   // falling edge
                end
                RX_START: begin
                    if (clk_cnt == CNT_W'(HALF - 1)) begin
                        clk_cnt <= '0;                            // now at mid-bit
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;   // drop glitches
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        done      <= rx_sync;
                        frame_err <= !rx_sync;
                        state     <= RX_IDLE;                     // still mid stop bit
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // payload shifter, no reset
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_end) shift <= {rx_sync, shift[7:1]};
    end

    assign data = shift;

endmodule

// File: src/uart_tx.sv
// ==================================================
// UART transmitter, 8N1
// one frame per start strobe, fixed bit period
// ==================================================

`timescale 1ns/1ns

module uart_tx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       start,                       // ignored while busy
    input  logic [7:0] data,
    output logic       tx,
    output logic       busy
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    logic [9:0]       shift;                        // stop, data, start
    logic [CNT_W-1:0] clk_cnt;                      // cycles within a bit
    logic [3:0]       bit_cnt;                      // bits sent, 0..9

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            shift   <= '1;                          // line idles high
            clk_cnt <= '0;
            bit_cnt <= '0;
            busy    <= 1'b0;
        end else if (start && !busy) begin
            shift   <= {1'b1, data, 1'b0};          // start bit goes out next cycle
            clk_cnt <= '0;
            bit_cnt <= '0;
            busy    <= 1'b1;
        end else if (busy) begin
            if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                clk_cnt <= '0;
                shift   <= {1'b1, shift[9:1]};      // refill with idle level
                if (bit_cnt == 4'd9) begin
                    busy <= 1'b0;                   // end of stop bit
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else begin
                clk_cnt <= clk_cnt + CNT_W'(1);
            end
        end
    end

    assign tx = shift[0];                           // straight from a flop

endmodule

// File: src/uart_bus_decode.sv
// ==================================================
// host address decoder
// channel select from the upper address bits, the
// register offset goes to every channel
// ==================================================

`timescale 1ns/1ns

module uart_bus_decode import uart_pkg::*; #(
    parameter  int NUM_CH = 2,
    localparam int SEL_W  = (NUM_CH > 1) ? $clog2(NUM_CH) : 1
) (
    input  logic                    en,
    input  logic                    wr,
    input  logic [SEL_W+REG_AW-1:0] addr,
    input  logic [7:0]              wdata,
    uart_bus_if.host                ch [NUM_CH],
    output logic [SEL_W-1:0]        sel
);

    logic [SEL_W-1:0]  ch_idx;                      // upper address bits
    logic [REG_AW-1:0] reg_off;                     // lower address bits

    assign ch_idx  = addr[SEL_W+REG_AW-1:REG_AW];
    assign reg_off = addr[REG_AW-1:0];
    assign sel     = ch_idx;                        // read mux picks this one

    for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
        // en only reaches the addressed channel
        assign ch[i].en    = en && (ch_idx == SEL_W'(i));
        assign ch[i].wr    = wr;                    // broadcast
        assign ch[i].addr  = reg_off;
        assign ch[i].wdata = wdata;
    end

endmodule

// File: src/uart_bus_if.sv
// ==================================================
// register bus of one UART channel
// strobes and write data from the decoder, read data
// back from the channel
// ==================================================

`timescale 1ns/1ns

interface uart_bus_if import uart_pkg::*; ();

    logic              en;                          // access strobe, one cycle
    logic              wr;                          // 1 = write, 0 = read
    logic [REG_AW-1:0] addr;                        // register offset
    logic [7:0]        wdata;
    logic [7:0]        rdata;                       // comb, addressed register

    // decoder side
    modport host (output en, wr, addr, wdata, input rdata);

    // read mux side, only looks at read data
    modport host_rd (input rdata);

    // channel side
    modport channel (input en, wr, addr, wdata, output rdata);

endinterface

// File: src/uart_pkg.sv
// ==================================================
// shared definitions for the multi-channel UART
// register offsets, receiver FSM states and the
// STATUS bit positions
// ==================================================

package uart_pkg;

    // register offset width per channel
    localparam int REG_AW = 4;                      // same as the single-UART bus

    // channel register map
    typedef enum logic [REG_AW-1:0] {
        REG_DATA   = 4'd0,                          // tx on write, rx byte on read
        REG_STATUS = 4'd1                           // flags, read clears errors
    } reg_addr_e;

    // receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE,                                    // waiting for falling edge
        RX_START,                                   // confirm start bit at mid-bit
        RX_DATA,                                    // 8 data bits, lsb first
        RX_STOP                                     // stop bit check
    } rx_state_e;

    // STATUS byte layout
    localparam int STAT_TX_BUSY   = 0;              // frame in flight
    localparam int STAT_RX_VALID  = 1;              // unread byte in DATA
    localparam int STAT_OVERRUN   = 2;              // byte lost before read
    localparam int STAT_FRAME_ERR = 3;              // stop bit was low

endpackage
